// ==== tmem_top.f ====
tmem_pkg.sv
tmem_array.sv
tmem_service_regs.sv
tmem_sequencer.sv
tmem_top.sv
tmem_checker.sv
tb_tmem_top.sv

// ==== tb_tmem_top.sv ====
/*
 * directed testbench for the tagged memory
 * reset, batch store/load, write protection, saved address, parity check
 * reference model of words, pointer and service registers
 */
module tb_tmem_top;
    import tmem_pkg::*;

    localparam int ADDR_W     = 10;
    localparam int TOP_ADDR   = (1 << ADDR_W) - 1;
    localparam int ADDR_SYN   = TOP_ADDR - SVC_SYN_OFS;
    localparam int ADDR_LADDR = TOP_ADDR - SVC_LADDR_OFS;
    localparam int ADDR_ECC   = TOP_ADDR - SVC_ECC_OFS;

    logic              clk = 1'b0;
    logic              i_arst_n;
    logic [DATA_W-1:0] i_ad;
    logic [TAG_W-1:0]  i_tag;
    logic              i_astb;
    logic              i_rd;
    logic              i_wr;
    logic              i_wforce;
    logic [DATA_W-1:0] o_data;
    logic [TAG_W-1:0]  o_tag;

    // reference model
    logic [DATA_W-1:0] m_data [int];
    logic [TAG_W-1:0]  m_tag [int];
    bit                m_bad [int];             // stored with byte-0 check flipped
    int                m_ptr;
    int                m_laddr;
    logic [ECC_W-1:0]  m_ecc;
    logic [CHK_W-1:0]  m_syn;

    int checks;
    int errors;
    int base;                                   // batch base, reused by later tests

    tmem_top #(.ADDR_W(ADDR_W)) u_tmem_top (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_ad     (i_ad),
        .i_tag    (i_tag),
        .i_astb   (i_astb),
        .i_rd     (i_rd),
        .i_wr     (i_wr),
        .i_wforce (i_wforce),
        .o_data   (o_data),
        .o_tag    (o_tag)
    );

    always #2 clk = ~clk;

    function automatic bit is_service(input int a);
        return (a == ADDR_SYN) || (a == ADDR_LADDR) || (a == ADDR_ECC);
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input int a);
        return m_tag.exists(a) ? m_tag[a] : '0;     // unwritten tags read zero
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // one rising edge, then back to idle inputs on the falling edge
    task automatic step();
        @(posedge clk);
        @(negedge clk);
        i_astb   = 1'b0;
        i_rd     = 1'b0;
        i_wr     = 1'b0;
        i_wforce = 1'b0;
    endtask

    task automatic strobe(input int addr);
        i_astb = 1'b1;
        i_ad   = 64'(addr);
        step();
        m_laddr = m_ptr;                        // old pointer is saved
        m_ptr   = addr;
        check_val("o_tag", 64'(is_service(addr) ? '0 : tag_of(addr)), 64'(o_tag));
    endtask

    task automatic store(input logic [DATA_W-1:0] data, input logic [TAG_W-1:0] tag,
                         input bit force_wr);
        logic [TAG_W-1:0] cur_tag;
        cur_tag  = tag_of(m_ptr);
        i_wr     = 1'b1;
        i_ad     = data;
        i_tag    = tag;
        i_wforce = force_wr;
        step();
        if (m_ptr == ADDR_ECC) begin
            m_ecc = data[ECC_W-1:0];            // pointer stays
        end else if (!is_service(m_ptr) && (force_wr || !cur_tag[TAG_PROTECT_BIT])) begin
            m_data[m_ptr] = data;
            m_tag[m_ptr]  = tag;
            m_bad[m_ptr]  = m_ecc[ECC_INJ_BIT];
            m_ptr++;
        end
    endtask

    task automatic load_check();
        logic [DATA_W-1:0] exp;
        i_rd = 1'b1;
        step();
        if (is_service(m_ptr)) begin
            case (m_ptr)
                ADDR_SYN: begin
                    exp   = 64'(m_syn);
                    m_syn = '0;                 // clear on read
                end
                ADDR_LADDR: exp = 64'(m_laddr);
                default:    exp = 64'(m_ecc);
            endcase
            check_val("o_data", exp, o_data);
        end else begin
            exp = m_data.exists(m_ptr) ? m_data[m_ptr] : 'x;
            check_val("o_data", exp, o_data);
            check_val("o_tag", 64'(tag_of(m_ptr)), 64'(o_tag));
            if (m_ecc[ECC_EN_BIT] && m_bad.exists(m_ptr) && m_bad[m_ptr])
                m_syn = m_syn | 9'h001;         // byte-0 parity mismatch
            m_ptr++;
        end
    endtask

    task automatic log_test(input string name, input int errs_before);
        $display("%s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic reset_state();
        int e0;
        int n;
        e0 = errors;
        n  = 0;
        while ($isunknown(o_tag) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n == 20) begin
            $display("o_tag stayed unknown for 20 cycles after reset");
            errors++;
        end
        check_val("o_data", '0, o_data);
        check_val("o_tag", '0, 64'(o_tag));
        strobe(ADDR_LADDR);
        load_check();                           // saved pointer is zero
        log_test("reset_state", e0);
    endtask

    task automatic batch_access();
        int e0;
        logic [TAG_W-1:0] tag;
        e0   = errors;
        base = $urandom % (ADDR_ECC - 16);
        strobe(base);
        for (int i = 0; i < 8; i++) begin
            tag = TAG_W'($urandom);
            tag[TAG_PROTECT_BIT] = 1'b0;
            store({$urandom, $urandom}, tag, 1'b0);
        end
        strobe(base);                           // o_tag shows the base word
        for (int i = 0; i < 8; i++)
            load_check();
        log_test("batch_access", e0);
    endtask

    task automatic write_protect();
        int e0;
        int y;
        logic [TAG_W-1:0] tag;
        logic [DATA_W-1:0] new_data;
        e0  = errors;
        y   = base + 9;
        tag = TAG_W'($urandom);
        tag[TAG_PROTECT_BIT] = 1'b1;
        new_data = {$urandom, $urandom};
        strobe(y);
        store({$urandom, $urandom}, tag, 1'b0);
        strobe(y);
        store(new_data, 8'($urandom), 1'b0);    // blocked
        load_check();                           // old word
        strobe(y);
        store(new_data, 8'($urandom), 1'b1);    // forced
        strobe(y);
        load_check();
        check_val("o_data", new_data, o_data);
        log_test("write_protect", e0);
    endtask

    task automatic saved_address();
        int e0;
        e0 = errors;
        i_wr = 1'b1;                            // strobe outranks the store
        strobe(base);
        load_check();
        load_check();
        strobe(ADDR_LADDR);
        load_check();
        check_val("o_data", 64'(base + 2), o_data);
        log_test("saved_address", e0);
    endtask

    task automatic parity_check();
        int e0;
        int x;
        e0 = errors;
        x  = base + 10;
        strobe(ADDR_ECC);
        store(64'd3, '0, 1'b0);                 // check on, inject on
        strobe(x);
        store({$urandom, $urandom}, 8'($urandom), 1'b0);
        strobe(ADDR_ECC);
        store(64'd1, '0, 1'b0);                 // check only
        strobe(x);
        load_check();
        strobe(ADDR_SYN);
        load_check();
        check_val("o_data", 64'h001, o_data);
        load_check();                           // cleared by the first read
        check_val("o_data", '0, o_data);
        strobe(base);
        load_check();                           // clean word
        strobe(ADDR_SYN);
        load_check();
        check_val("o_data", '0, o_data);
        strobe(ADDR_ECC);
        load_check();
        check_val("o_data", 64'd1, o_data);
        log_test("parity_check", e0);
    endtask

    // run limit
    initial begin
        for (int i = 0; i < 5000; i++)
            @(posedge clk);
        $display("run did not finish within 5000 cycles");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h3e65_47e3));
        i_arst_n = 1'b0;
        i_ad     = '0;
        i_tag    = '0;
        i_astb   = 1'b0;
        i_rd     = 1'b0;
        i_wr     = 1'b0;
        i_wforce = 1'b0;
        m_ptr    = 0;
        m_laddr  = 0;
        m_ecc    = '0;
        m_syn    = '0;
        checks   = 0;
        errors   = 0;
        repeat (8) @(negedge clk);
        i_arst_n = 1'b1;
        reset_state();
        batch_access();
        write_protect();
        saved_address();
        parity_check();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tmem_checker.sv ====
/*
 * concurrent assertions on the bus sequencer
 * strobe vs array write, blocked store, o_tag known after reset
 * bound into every tmem_sequencer instance
 */
module tmem_checker #(
    parameter int ADDR_W = 20
) (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_astb,        // raw bus strobes
    input  logic                         i_rd,
    input  logic                         i_wr,
    input  logic                         i_wforce,
    input  logic                         i_arr_we,
    input  logic [tmem_pkg::TAG_W-1:0]   i_arr_tag,     // tag of the addressed word
    input  logic [ADDR_W-1:0]            i_ptr,         // batch pointer
    input  logic [tmem_pkg::TAG_W-1:0]   i_tag_out
);
    import tmem_pkg::*;

    // lowest service address, everything below is memory
    localparam logic [ADDR_W-1:0] FIRST_SVC = {ADDR_W{1'b1}} - ADDR_W'(SVC_ECC_OFS);

    // strobe outranks write, so the array must stay untouched
    a_no_write_on_strobe: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_astb |-> !i_arr_we
    ) else $error("array write enable high in an address strobe cycle");

    // protected memory word, plain store, no force
    a_blocked_store_holds_ptr: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_wr && !i_astb && !i_rd && !i_wforce && (i_ptr < FIRST_SVC)
            && i_arr_tag[TAG_PROTECT_BIT]) |=> $stable(i_ptr)
    ) else $error("pointer moved after a blocked store");

    a_tag_known: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !$isunknown(i_tag_out)
    ) else $error("o_tag has unknown bits");

endmodule

bind tmem_sequencer tmem_checker #(.ADDR_W(ADDR_W)) u_chk (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_astb     (i_astb),
    .i_rd       (i_rd),
    .i_wr       (i_wr),
    .i_wforce   (i_wforce),
    .i_arr_we   (o_arr_we),
    .i_arr_tag  (i_arr_tag),
    .i_ptr      (ptr_q),
    .i_tag_out  (o_tag)
);

// ==== tmem_top.sv ====
/*
 * tagged memory top level
 * sequencer, word arrays and service registers
 */
module tmem_top #(
    parameter int ADDR_W = 20
) (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  logic [tmem_pkg::DATA_W-1:0]   i_ad,     // address or data
    input  logic [tmem_pkg::TAG_W-1:0]    i_tag,
    input  logic                          i_astb,
    input  logic                          i_rd,
    input  logic                          i_wr,
    input  logic                          i_wforce,
    output logic [tmem_pkg::DATA_W-1:0]   o_data,
    output logic [tmem_pkg::TAG_W-1:0]    o_tag
);
    import tmem_pkg::*;

    // sequencer <-> array
    logic [ADDR_W-1:0] arr_addr;
    logic              arr_we;
    logic              arr_re;
    logic [DATA_W-1:0] arr_wdata;
    logic [TAG_W-1:0]  arr_wtag;
    logic [CHK_W-1:0]  arr_wchk;
    logic [TAG_W-1:0]  arr_tag;
    logic [DATA_W-1:0] arr_data;
    logic [CHK_W-1:0]  arr_chk;

    // sequencer <-> service regs
    tmem_svc_e         svc_sel;
    logic              svc_rd;
    logic              svc_wr;
    logic              svc_astb;
    logic [ADDR_W-1:0] old_addr;
    logic              syn_cap;
    logic [CHK_W-1:0]  syndrome;
    logic [DATA_W-1:0] svc_data;
    logic [ECC_W-1:0]  ecc_mode;

    tmem_sequencer #(.ADDR_W(ADDR_W)) u_seq (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_ad        (i_ad),
        .i_tag       (i_tag),
        .i_astb      (i_astb),
        .i_rd        (i_rd),
        .i_wr        (i_wr),
        .i_wforce    (i_wforce),
        .i_arr_tag   (arr_tag),
        .i_arr_data  (arr_data),
        .i_arr_chk   (arr_chk),
        .i_svc_data  (svc_data),
        .i_ecc_mode  (ecc_mode),
        .o_arr_addr  (arr_addr),
        .o_arr_we    (arr_we),
        .o_arr_re    (arr_re),
        .o_arr_wdata (arr_wdata),
        .o_arr_wtag  (arr_wtag),
        .o_arr_wchk  (arr_wchk),
        .o_svc_sel   (svc_sel),
        .o_svc_rd    (svc_rd),
        .o_svc_wr    (svc_wr),
        .o_astb      (svc_astb),
        .o_old_addr  (old_addr),
        .o_syn_cap   (syn_cap),
        .o_syndrome  (syndrome),
        .o_data      (o_data),
        .o_tag       (o_tag)
    );

    tmem_array #(.ADDR_W(ADDR_W)) u_arr (
        .clk     (clk),
        .i_addr  (arr_addr),
        .i_we    (arr_we),
        .i_re    (arr_re),
        .i_wdata (arr_wdata),
        .i_wtag  (arr_wtag),
        .i_wchk  (arr_wchk),
        .o_rtag  (arr_tag),
        .o_rdata (arr_data),
        .o_rchk  (arr_chk)
    );

    // ecc mode takes the low bus bits on a service store
    tmem_service_regs #(.ADDR_W(ADDR_W)) u_svc (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_svc_sel  (svc_sel),
        .i_svc_rd   (svc_rd),
        .i_svc_wr   (svc_wr),
        .i_wdata    (i_ad[ECC_W-1:0]),
        .i_astb     (svc_astb),
        .i_old_addr (old_addr),
        .i_syn_cap  (syn_cap),
        .i_syndrome (syndrome),
        .o_rdata    (svc_data),
        .o_ecc_mode (ecc_mode)
    );

endmodule

// ==== tmem_sequencer.sv ====
/*
 * bus sequencer for the tagged memory
 * strobe/load/store decode, batch word pointer, write protection
 * parity generation with error injection, load check one stage later
 * registered data and tag outputs
 */
module tmem_sequencer #(
    parameter int ADDR_W = 20
) (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  logic [tmem_pkg::DATA_W-1:0]   i_ad,         // shared address/data bus
    input  logic [tmem_pkg::TAG_W-1:0]    i_tag,
    input  logic                          i_astb,
    input  logic                          i_rd,
    input  logic                          i_wr,
    input  logic                          i_wforce,     // ignore protect bit
    input  logic [tmem_pkg::TAG_W-1:0]    i_arr_tag,
    input  logic [tmem_pkg::DATA_W-1:0]   i_arr_data,
    input  logic [tmem_pkg::CHK_W-1:0]    i_arr_chk,
    input  logic [tmem_pkg::DATA_W-1:0]   i_svc_data,
    input  logic [tmem_pkg::ECC_W-1:0]    i_ecc_mode,
    output logic [ADDR_W-1:0]             o_arr_addr,
    output logic                          o_arr_we,
    output logic                          o_arr_re,
    output logic [tmem_pkg::DATA_W-1:0]   o_arr_wdata,
    output logic [tmem_pkg::TAG_W-1:0]    o_arr_wtag,
    output logic [tmem_pkg::CHK_W-1:0]    o_arr_wchk,
    output tmem_pkg::tmem_svc_e           o_svc_sel,
    output logic                          o_svc_rd,
    output logic                          o_svc_wr,
    output logic                          o_astb,
    output logic [ADDR_W-1:0]             o_old_addr,
    output logic                          o_syn_cap,
    output logic [tmem_pkg::CHK_W-1:0]    o_syndrome,
    output logic [tmem_pkg::DATA_W-1:0]   o_data,
    output logic [tmem_pkg::TAG_W-1:0]    o_tag
);
    import tmem_pkg::*;

    localparam logic [ADDR_W-1:0] ADDR_SYN   = {ADDR_W{1'b1}} - ADDR_W'(SVC_SYN_OFS);
    localparam logic [ADDR_W-1:0] ADDR_LADDR = {ADDR_W{1'b1}} - ADDR_W'(SVC_LADDR_OFS);
    localparam logic [ADDR_W-1:0] ADDR_ECC   = {ADDR_W{1'b1}} - ADDR_W'(SVC_ECC_OFS);

    tmem_op_e          op;
    tmem_svc_e         svc_sel;
    logic [ADDR_W-1:0] ptr_q;           // batch word pointer
    logic              is_mem;          // addressed word is real memory
    logic              protected_w;     // protect bit of current word
    logic              store_ok;        // memory store allowed this cycle
    logic [TAG_W-1:0]  addr_tag;        // tag shown for a new position
    logic [DATA_W-1:0] svc_data_q;      // last service load result
    logic              src_mem_q;       // o_data from array registers
    logic              load_q;          // memory load one cycle ago
    logic              tag_follow_q;    // o_tag refresh after a store
    logic [CHK_W-1:0]  wchk;

    // strobe wins over read, read over write
    always_comb begin
        if (i_astb)
            op = OP_LATCH;
        else if (i_rd)
            op = OP_LOAD;
        else if (i_wr)
            op = OP_STORE;
        else
            op = OP_IDLE;
    end

    // a strobe looks ahead at the incoming address for the tag prefetch
    assign o_arr_addr = (op == OP_LATCH) ? i_ad[ADDR_W-1:0] : ptr_q;

    always_comb begin
        case (o_arr_addr)
            ADDR_SYN:   svc_sel = SVC_SYNDROME;
            ADDR_LADDR: svc_sel = SVC_LADDR;
            ADDR_ECC:   svc_sel = SVC_ECCMODE;
            default:    svc_sel = SVC_NONE;
        endcase
    end

    assign is_mem      = (svc_sel == SVC_NONE);
    assign addr_tag    = is_mem ? i_arr_tag : '0;   // service words have no tag
    assign protected_w = i_arr_tag[TAG_PROTECT_BIT];
    assign store_ok    = (op == OP_STORE) && is_mem && (i_wforce || !protected_w);

    // store path, byte-0 check bit flipped when injecting
    always_comb begin
        wchk    = calc_check(i_ad, i_tag);
        wchk[0] = wchk[0] ^ i_ecc_mode[ECC_INJ_BIT];
    end

    assign o_arr_we    = store_ok;
    assign o_arr_re    = (op == OP_LOAD) && is_mem;
    assign o_arr_wdata = i_ad;
    assign o_arr_wtag  = i_tag;
    assign o_arr_wchk  = wchk;

    // service side
    assign o_svc_sel  = svc_sel;
    assign o_svc_rd   = (op == OP_LOAD) && !is_mem;
    assign o_svc_wr   = (op == OP_STORE) && (svc_sel == SVC_ECCMODE);
    assign o_astb     = (op == OP_LATCH);
    assign o_old_addr = ptr_q;

    // check stage, o_tag still holds the loaded word's tag
    assign o_syndrome = calc_check(i_arr_data, o_tag) ^ i_arr_chk;
    assign o_syn_cap  = load_q && i_ecc_mode[ECC_EN_BIT];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ptr_q        <= '0;
            o_tag        <= '0;
            svc_data_q   <= '0;
            src_mem_q    <= 1'b0;
            load_q       <= 1'b0;
            tag_follow_q <= 1'b0;
        end else begin
            load_q       <= o_arr_re;
            tag_follow_q <= store_ok;
            case (op)
                OP_LATCH: begin
                    ptr_q <= i_ad[ADDR_W-1:0];
                    o_tag <= addr_tag;              // early tag for protection
                end
                OP_LOAD: begin
                    if (is_mem) begin
                        src_mem_q <= 1'b1;
                        o_tag     <= i_arr_tag;
                        ptr_q     <= ptr_q + 1'b1;  // batch mode
                    end else begin
                        src_mem_q  <= 1'b0;
                        svc_data_q <= i_svc_data;   // pointer stays
                    end
                end
                default: begin
                    if (store_ok)
                        ptr_q <= ptr_q + 1'b1;
                    // show the next word's tag once the pointer moved on
                    if (tag_follow_q)
                        o_tag <= addr_tag;
                end
            endcase
        end
    end

    assign o_data = src_mem_q ? i_arr_data : svc_data_q;

endmodule

// ==== tmem_service_regs.sv ====
/*
 * service locations at the top of the address space
 * ecc mode register, saved strobe address, sticky syndrome
 * read mux for service loads, zero extended to the data width
 */
module tmem_service_regs #(
    parameter int ADDR_W = 20
) (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  tmem_pkg::tmem_svc_e           i_svc_sel,    // location named by pointer
    input  logic                          i_svc_rd,     // service load
    input  logic                          i_svc_wr,     // service store
    input  logic [tmem_pkg::ECC_W-1:0]    i_wdata,      // low bits of the bus
    input  logic                          i_astb,       // address strobe pulse
    input  logic [ADDR_W-1:0]             i_old_addr,   // pointer before strobe
    input  logic                          i_syn_cap,    // checked load result valid
    input  logic [tmem_pkg::CHK_W-1:0]    i_syndrome,
    output logic [tmem_pkg::DATA_W-1:0]   o_rdata,
    output logic [tmem_pkg::ECC_W-1:0]    o_ecc_mode
);
    import tmem_pkg::*;

    logic [ECC_W-1:0]  ecc_q;
    logic [ADDR_W-1:0] laddr_q;
    logic [CHK_W-1:0]  syn_q;
    logic              syn_clr;
    logic [CHK_W-1:0]  syn_base;

    assign syn_clr  = i_svc_rd && (i_svc_sel == SVC_SYNDROME);  // read clears
    assign syn_base = syn_clr ? '0 : syn_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ecc_q   <= '0;
            laddr_q <= '0;
            syn_q   <= '0;
        end else begin
            if (i_svc_wr && (i_svc_sel == SVC_ECCMODE))
                ecc_q <= i_wdata;
            if (i_astb)
                laddr_q <= i_old_addr;      // remember last r/w position
            // a capture in the same cycle as the clearing read survives
            if (i_syn_cap)
                syn_q <= syn_base | i_syndrome;
            else
                syn_q <= syn_base;
        end
    end

    assign o_ecc_mode = ecc_q;

    // read value, sequencer registers it
    always_comb begin
        case (i_svc_sel)
            SVC_SYNDROME: o_rdata = DATA_W'(syn_q);
            SVC_LADDR:    o_rdata = DATA_W'(laddr_q);
            SVC_ECCMODE:  o_rdata = DATA_W'(ecc_q);
            default:      o_rdata = '0;     // not a service location
        endcase
    end

endmodule

// ==== tmem_array.sv ====
/*
 * tagged word storage
 * data, tag and check-bit arrays indexed by word address
 * tag read is combinational, data and check bits read into registers
 */
module tmem_array #(
    parameter int ADDR_W = 20
) (
    input  logic                          clk,
    input  logic [ADDR_W-1:0]             i_addr,   // word pointer or strobe address
    input  logic                          i_we,     // store pulse
    input  logic                          i_re,     // load pulse
    input  logic [tmem_pkg::DATA_W-1:0]   i_wdata,
    input  logic [tmem_pkg::TAG_W-1:0]    i_wtag,
    input  logic [tmem_pkg::CHK_W-1:0]    i_wchk,
    output logic [tmem_pkg::TAG_W-1:0]    o_rtag,   // same-cycle tag of i_addr
    output logic [tmem_pkg::DATA_W-1:0]   o_rdata,  // registered on i_re
    output logic [tmem_pkg::CHK_W-1:0]    o_rchk    // registered on i_re
);
    import tmem_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] data_mem [DEPTH];
    // 2-state tag store, a never-written word reads as unprotected, tag 0
    bit   [TAG_W-1:0]  tag_mem  [DEPTH];
    logic [CHK_W-1:0]  chk_mem  [DEPTH];

    // write port, one word per store
    always_ff @(posedge clk) begin
        if (i_we) begin
            data_mem[i_addr] <= i_wdata;
            tag_mem[i_addr]  <= i_wtag;
            chk_mem[i_addr]  <= i_wchk;     // possibly with injected error
        end
    end

    // tag is needed before the edge
    // for the protect test and the strobe prefetch
    assign o_rtag = tag_mem[i_addr];

    // data path read, no reset on payload
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= data_mem[i_addr];
            o_rchk  <= chk_mem[i_addr];     // checked one stage later
        end
    end

endmodule

// ==== tmem_pkg.sv ====
/*
 * shared constants for the tagged memory
 * word, tag and check-bit widths, protect bit, service offsets
 * operation and service-select enums, parity check-bit function
 */
package tmem_pkg;

    localparam int DATA_W = 64;             // data word
    localparam int TAG_W  = 8;              // tag per word
    localparam int CHK_W  = 9;              // 8 byte parities + tag parity

    localparam int TAG_PROTECT_BIT = 3;     // set = store blocked unless forced

    // service locations, counted down from all-ones
    localparam int SVC_SYN_OFS   = 0;       // sticky syndrome, clear on read
    localparam int SVC_LADDR_OFS = 1;       // pointer saved at last strobe
    localparam int SVC_ECC_OFS   = 2;       // ecc mode register

    localparam int ECC_W       = 2;
    localparam int ECC_EN_BIT  = 0;         // check loads
    localparam int ECC_INJ_BIT = 1;         // flip byte-0 check bit on stores

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_LATCH,                           // address strobe
        OP_LOAD,
        OP_STORE
    } tmem_op_e;

    typedef enum logic [1:0] {
        SVC_NONE,                           // plain memory word
        SVC_SYNDROME,
        SVC_LADDR,
        SVC_ECCMODE
    } tmem_svc_e;

    // even parity per data byte, tag parity in the top bit
    function automatic logic [CHK_W-1:0] calc_check(input logic [DATA_W-1:0] data,
                                                     input logic [TAG_W-1:0]  tag);
        logic [CHK_W-1:0] chk;
        for (int b = 0; b < DATA_W / 8; b++) begin
            chk[b] = ^data[b*8 +: 8];
        end
        chk[CHK_W-1] = ^tag;
        return chk;
    endfunction

endpackage
